//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := dcache_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/data_store.sv
// two-way data array with byte strobes and write-first read
`include "dcache_macros.svh"

module data_store import dcache_pkg::*; (
    input  logic        clk,
    input  index_t      index_i,
    input  logic        we_i,
    input  logic        way_i,
    input  strb_t       strb_i,
    input  word_t       wdata_i,
    output word_t [1:0] rdata_o
);

    word_t      data_mem [`DC_SETS][2];
    word_t      merged;
    logic [1:0] wr_sel;

    assign wr_sel = we_i ? (way_i ? 2'b10 : 2'b01) : 2'b00;

    // old word with strobed bytes replaced
    always_comb begin
        merged = data_mem[index_i][way_i];
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strb_i[b]) begin
                merged[b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            data_mem[index_i][way_i] <= merged;
        end
        for (int w = 0; w < 2; w++) begin
            rdata_o[w] <= wr_sel[w] ? merged : data_mem[index_i][w];
        end
    end

endmodule

//--- hdl/dcache_ctrl.sv
// access FSM with CPU request/response and memory port logic
`include "dcache_macros.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        req_valid_i,
    input  logic        req_write_i,
    input  addr_t       req_addr_i,
    input  word_t       req_wdata_i,
    input  strb_t       req_strb_i,
    output logic        req_ready_o,
    output logic        resp_valid_o,
    output word_t       resp_rdata_o,
    output logic        mem_req_o,
    output logic        mem_we_o,
    output addr_t       mem_addr_o,
    output word_t       mem_wdata_o,
    input  logic        mem_ready_i,
    input  word_t       mem_rdata_i,
    output index_t      lookup_index_o,
    output tag_t        lookup_tag_o,
    output logic        tag_we_o,
    output logic        fill_way_o,
    output logic        data_we_o,
    output strb_t       data_strb_o,
    output word_t       data_wdata_o,
    output logic        touch_o,
    output logic        touch_way_o,
    output logic        set_dirty_o,
    output logic        clear_dirty_o,
    input  logic [1:0]  hit_i,
    input  tag_t [1:0]  way_tag_i,
    input  word_t [1:0] way_data_i,
    input  logic        victim_way_i,
    input  logic        victim_dirty_i
);

    cache_state_e state_q;
    cache_state_e state_d;
    logic         accept;
    logic         req_write_q;
    tag_t         req_tag_q;
    index_t       req_index_q;
    word_t        req_wdata_q;
    strb_t        req_strb_q;
    logic         hit_way;
    logic         target_way;

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // whole request captured so the CPU may move on
    always_ff @(posedge clk) begin
        if (accept) begin
            req_write_q <= req_write_i;
            req_tag_q   <= req_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
            req_index_q <= req_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
            req_wdata_q <= req_wdata_i;
            req_strb_q  <= req_strb_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (|hit_i) begin
                    state_d = HIT;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            HIT: state_d = IDLE;
            WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // retry the lookup, which now hits
                if (mem_ready_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // arrays see the incoming request while idle
    assign lookup_index_o = (state_q == IDLE) ?
                            req_addr_i[`DC_OFFSET_W +: `DC_INDEX_W] : req_index_q;
    assign lookup_tag_o   = (state_q == IDLE) ?
                            req_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W] : req_tag_q;

    assign hit_way    = hit_i[1];
    assign target_way = (state_q == HIT) ? hit_way : victim_way_i;

    assign resp_valid_o = (state_q == HIT);
    assign resp_rdata_o = way_data_i[hit_way];

    assign mem_req_o   = (state_q == WRITEBACK) || (state_q == REFILL);
    assign mem_we_o    = (state_q == WRITEBACK);
    assign mem_addr_o  = (state_q == WRITEBACK) ?
                         {way_tag_i[victim_way_i], req_index_q, {`DC_OFFSET_W{1'b0}}} :
                         {req_tag_q, req_index_q, {`DC_OFFSET_W{1'b0}}};
    assign mem_wdata_o = way_data_i[victim_way_i];

    assign tag_we_o     = (state_q == REFILL) && mem_ready_i;
    assign fill_way_o   = target_way;
    assign data_we_o    = tag_we_o || ((state_q == HIT) && req_write_q);
    assign data_strb_o  = (state_q == HIT) ? req_strb_q : '1;
    assign data_wdata_o = (state_q == HIT) ? req_wdata_q : mem_rdata_i;

    assign touch_o       = (state_q == HIT);
    assign touch_way_o   = target_way;
    assign set_dirty_o   = (state_q == HIT) && req_write_q;
    assign clear_dirty_o = mem_req_o && mem_ready_i;

    // a response always comes from exactly one hit way
    a_resp_one_hit: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_o |-> $onehot(hit_i));

    a_mem_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o && !mem_ready_i |=> $stable(mem_addr_o));

endmodule

//--- hdl/dcache_macros.svh
// cache geometry, field widths and age limit
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split is tag | index | byte offset
`define DC_ADDR_W   32
`define DC_WORD_W   64
`define DC_STRB_W   8
`define DC_TAG_W    23
`define DC_INDEX_W  6
`define DC_SETS     64
`define DC_OFFSET_W 3

// replacement age counters
`define DC_AGE_W    3
`define DC_AGE_MAX  7

`endif

//--- hdl/dcache_pkg.sv
// shared data cache types and controller state encoding
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]  addr_t;
    typedef logic [`DC_WORD_W-1:0]  word_t;
    typedef logic [`DC_STRB_W-1:0]  strb_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_AGE_W-1:0]   age_t;

    // one access at a time and misses loop back to LOOKUP
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WRITEBACK,
        REFILL
    } cache_state_e;

endpackage

//--- hdl/dcache_top.sv
// data cache top level with controller, tag, line state and data arrays
`include "dcache_macros.svh"

module dcache_top import dcache_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  req_valid_i,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  word_t req_wdata_i,
    input  strb_t req_strb_i,
    output logic  req_ready_o,
    output logic  resp_valid_o,
    output word_t resp_rdata_o,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o,
    input  logic  mem_ready_i,
    input  word_t mem_rdata_i
);

    index_t      lookup_index;
    tag_t        lookup_tag;
    logic        tag_we;
    logic        fill_way;
    logic        data_we;
    strb_t       data_strb;
    word_t       data_wdata;
    logic        touch;
    logic        touch_way;
    logic        set_dirty;
    logic        clear_dirty;
    logic [1:0]  hit;
    logic [1:0]  way_valid;
    tag_t [1:0]  way_tag;
    word_t [1:0] way_data;
    logic        victim_way;
    logic        victim_dirty;

    dcache_ctrl dcache_ctrl_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_strb_i     (req_strb_i),
        .req_ready_o    (req_ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rdata_i    (mem_rdata_i),
        .lookup_index_o (lookup_index),
        .lookup_tag_o   (lookup_tag),
        .tag_we_o       (tag_we),
        .fill_way_o     (fill_way),
        .data_we_o      (data_we),
        .data_strb_o    (data_strb),
        .data_wdata_o   (data_wdata),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .set_dirty_o    (set_dirty),
        .clear_dirty_o  (clear_dirty),
        .hit_i          (hit),
        .way_tag_i      (way_tag),
        .way_data_i     (way_data),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty)
    );

    tag_store tag_store_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .index_i (lookup_index),
        .tag_i   (lookup_tag),
        .we_i    (tag_we),
        .way_i   (fill_way),
        .hit_o   (hit),
        .valid_o (way_valid),
        .tag_o   (way_tag)
    );

    line_state line_state_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .index_i        (lookup_index),
        .valid_i        (way_valid),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .set_dirty_i    (set_dirty),
        .clear_dirty_i  (clear_dirty),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    data_store data_store_inst (
        .clk     (clk),
        .index_i (lookup_index),
        .we_i    (data_we),
        .way_i   (fill_way),
        .strb_i  (data_strb),
        .wdata_i (data_wdata),
        .rdata_o (way_data)
    );

endmodule

//--- hdl/line_state.sv
// per-set dirty bits and age counters with victim selection
`include "dcache_macros.svh"

module line_state import dcache_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  index_t     index_i,
    input  logic [1:0] valid_i,
    input  logic       touch_i,
    input  logic       touch_way_i,
    input  logic       set_dirty_i,
    input  logic       clear_dirty_i,
    output logic       victim_way_o,
    output logic       victim_dirty_o
);

    logic [1:0] dirty_q [`DC_SETS];
    age_t       age_q [`DC_SETS][2];
    logic       other_way;
    age_t       other_age;

    assign other_way = ~touch_way_i;
    assign other_age = age_q[index_i][other_way];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                dirty_q[s]  <= '0;
                age_q[s][0] <= '0;
                age_q[s][1] <= '0;
            end
        end else begin
            if (set_dirty_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end else if (clear_dirty_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b0;
            end
            if (touch_i) begin
                age_q[index_i][touch_way_i] <= '0;
                // saturate so an idle way stays the oldest
                if (other_age != `DC_AGE_MAX) begin
                    age_q[index_i][other_way] <= other_age + 1'b1;
                end
            end
        end
    end

    // empty ways first, then the older way, ties to way 0
    always_comb begin
        if (!valid_i[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = age_q[index_i][1] > age_q[index_i][0];
        end
    end

    assign victim_dirty_o = valid_i[victim_way_o] && dirty_q[index_i][victim_way_o];

endmodule

//--- hdl/tag_store.sv
// tag and valid arrays for both ways with registered hit compare
`include "dcache_macros.svh"

module tag_store import dcache_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  index_t     index_i,
    input  tag_t       tag_i,
    input  logic       we_i,
    input  logic       way_i,
    output logic [1:0] hit_o,
    output logic [1:0] valid_o,
    output tag_t [1:0] tag_o
);

    tag_t       tag_mem [`DC_SETS][2];
    logic [1:0] valid_mem [`DC_SETS];
    tag_t       cmp_tag_q;
    logic [1:0] wr_sel;

    assign wr_sel = we_i ? (way_i ? 2'b10 : 2'b01) : 2'b00;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_mem[s] <= '0;
            end
            valid_o <= '0;
        end else begin
            if (we_i) begin
                valid_mem[index_i][way_i] <= 1'b1;
            end
            // write-first read
            valid_o <= wr_sel | valid_mem[index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[index_i][way_i] <= tag_i;
        end
        for (int w = 0; w < 2; w++) begin
            tag_o[w] <= wr_sel[w] ? tag_i : tag_mem[index_i][w];
        end
        cmp_tag_q <= tag_i;
    end

    assign hit_o[0] = valid_o[0] && (tag_o[0] == cmp_tag_q);
    assign hit_o[1] = valid_o[1] && (tag_o[1] == cmp_tag_q);

    // refill only targets a missing tag, so one set never holds it twice
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(hit_o));

endmodule

//--- project.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/tag_store.sv
hdl/line_state.sv
hdl/data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/dcache_tb.sv

//--- tb/dcache_tb.sv
// data cache testbench with memory model, reference cache model, directed tests and watchdog
`include "dcache_macros.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int MAX_DELAY       = 5;
    localparam int RANDOM_ACCESSES = 40;
    localparam int NUM_ACCESSES    = 15 + RANDOM_ACCESSES;
    localparam int ACCESS_CYCLES   = 6 + 2 * (MAX_DELAY + 2);
    localparam int ACCESS_LIMIT    = 4 * ACCESS_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_ACCESSES * ACCESS_CYCLES + 14);

    logic  clk;
    logic  reset_i;
    logic  req_valid_i;
    logic  req_write_i;
    addr_t req_addr_i;
    word_t req_wdata_i;
    strb_t req_strb_i;
    logic  req_ready_o;
    logic  resp_valid_o;
    word_t resp_rdata_o;
    logic  mem_req_o;
    logic  mem_we_o;
    addr_t mem_addr_o;
    word_t mem_wdata_o;
    logic  mem_ready_i;
    word_t mem_rdata_i;

    int    seed = 37;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failing = 0;
    addr_t last_wb_addr;

    // memory seen by the DUT, and the memory the reference model expects
    word_t mem_q [addr_t];
    word_t exp_mem [addr_t];
    logic  log_we [$];
    addr_t log_addr [$];
    word_t log_data [$];

    // reference cache state
    logic  m_valid [`DC_SETS][2];
    logic  m_dirty [`DC_SETS][2];
    tag_t  m_tag [`DC_SETS][2];
    word_t m_data [`DC_SETS][2];
    int    m_age [`DC_SETS][2];

    dcache_top dcache_top_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t fill_word(input addr_t a);
        return {a ^ 32'h5a5a_c3c3, ~a};
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
    endfunction

    function automatic addr_t align_addr(input addr_t a);
        return {a[`DC_ADDR_W-1:`DC_OFFSET_W], 3'b000};
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i, input logic [2:0] o);
        return {t, i, o};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // memory responder with random ready delay
    initial begin
        logic  t_we;
        addr_t t_addr;
        word_t t_wdata;
        int    delay;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (mem_req_o && !reset_i) begin
                t_we    = mem_we_o;
                t_addr  = mem_addr_o;
                t_wdata = mem_wdata_o;
                delay   = $unsigned($random(seed)) % (MAX_DELAY + 1);
                repeat (delay) begin
                    @(negedge clk);
                    check_value("mem_req_o", 64'd1, 64'(mem_req_o));
                    check_value("mem_we_o", 64'(t_we), 64'(mem_we_o));
                    check_value("mem_addr_o", 64'(t_addr), 64'(mem_addr_o));
                    check_value("mem_wdata_o", t_wdata, mem_wdata_o);
                end
                if (t_we) begin
                    mem_q[t_addr] = t_wdata;
                end else begin
                    mem_rdata_i = mem_q.exists(t_addr) ? mem_q[t_addr] : fill_word(t_addr);
                end
                log_we.push_back(t_we);
                log_addr.push_back(t_addr);
                log_data.push_back(t_wdata);
                mem_ready_i = 1'b1;
                @(negedge clk);
                mem_ready_i = 1'b0;
            end
        end
    end

    // expected outcome of one access, applied to the reference cache
    task automatic model_access(input logic wr, input addr_t addr, input word_t wdata,
                                input strb_t strb, output logic miss, output logic wb,
                                output addr_t wb_addr, output word_t wb_data,
                                output word_t rdata);
        index_t idx;
        tag_t   tag;
        logic   way;
        logic   other;
        idx     = addr[`DC_OFFSET_W +: `DC_INDEX_W];
        tag     = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        miss    = 1'b1;
        wb      = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        way     = 1'b0;
        if (m_valid[idx][0] && m_tag[idx][0] == tag) begin
            miss = 1'b0;
        end else if (m_valid[idx][1] && m_tag[idx][1] == tag) begin
            miss = 1'b0;
            way  = 1'b1;
        end
        if (miss) begin
            if (!m_valid[idx][0]) begin
                way = 1'b0;
            end else if (!m_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = m_age[idx][1] > m_age[idx][0];
            end
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                wb               = 1'b1;
                wb_addr          = {m_tag[idx][way], idx, 3'b000};
                wb_data          = m_data[idx][way];
                exp_mem[wb_addr] = wb_data;
            end
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way]   = tag;
            m_data[idx][way]  = expected_word(align_addr(addr));
        end
        other = ~way;
        m_age[idx][way] = 0;
        if (m_age[idx][other] < `DC_AGE_MAX) begin
            m_age[idx][other]++;
        end
        if (wr) begin
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (strb[b]) begin
                    m_data[idx][way][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            m_dirty[idx][way] = 1'b1;
        end
        rdata = m_data[idx][way];
    endtask

    task automatic access(input logic wr, input addr_t addr, input word_t wdata,
                          input strb_t strb);
        logic  miss;
        logic  wb;
        addr_t wb_addr;
        word_t wb_data;
        word_t exp_rdata;
        int    cycles;
        model_access(wr, addr, wdata, strb, miss, wb, wb_addr, wb_data, exp_rdata);
        log_we.delete();
        log_addr.delete();
        log_data.delete();
        last_wb_addr = '1;
        @(negedge clk);
        while (!req_ready_o) begin
            @(negedge clk);
        end
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_strb_i  = strb;
        @(negedge clk);
        // scramble the inputs since the request is already registered
        req_valid_i = 1'b0;
        req_write_i = ~wr;
        req_addr_i  = ~addr;
        req_wdata_i = ~wdata;
        req_strb_i  = ~strb;
        cycles = 1;
        while (!resp_valid_o && cycles < ACCESS_LIMIT) begin
            if (!miss) begin
                check_value("mem_req_o", 64'd0, 64'(mem_req_o));
            end
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid_o) begin
            $display("no response to the access at %h after %0d cycles", addr, cycles);
            errors++;
            return;
        end
        if (!miss) begin
            check_value("mem_req_o", 64'd0, 64'(mem_req_o));
        end
        if (!wr) begin
            check_value("resp_rdata_o", exp_rdata, resp_rdata_o);
        end
        if (!miss) begin
            check_value("hit latency", 64'd2, 64'(cycles));
        end
        check_value("memory transfers", 64'(miss ? (wb ? 2 : 1) : 0), 64'(log_we.size()));
        if (log_we.size() > 0 && log_we[0]) begin
            last_wb_addr = log_addr[0];
        end
        if (wb && log_we.size() == 2) begin
            check_value("writeback mem_we_o", 64'd1, 64'(log_we[0]));
            check_value("writeback mem_addr_o", 64'(wb_addr), 64'(log_addr[0]));
            check_value("writeback mem_wdata_o", wb_data, log_data[0]);
        end
        if (miss && log_we.size() > 0) begin
            check_value("refill mem_we_o", 64'd0, 64'(log_we[$]));
            check_value("refill mem_addr_o", 64'(align_addr(addr)), 64'(log_addr[$]));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failing++;
            $display("%s: %0d checks wrong", name, errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_value("req_ready_o", 64'd1, 64'(req_ready_o));
        check_value("resp_valid_o", 64'd0, 64'(resp_valid_o));
        check_value("mem_req_o", 64'd0, 64'(mem_req_o));
        finish_test("reset", e0);
    endtask

    task automatic test_read_miss_hit();
        int    e0;
        addr_t a;
        e0 = errors;
        a  = make_addr(23'h01234, 6'd3, 3'd5);
        access(1'b0, a, '0, '0);
        access(1'b0, a, '0, '0);
        finish_test("read_miss_hit", e0);
    endtask

    task automatic test_write_merge();
        int    e0;
        addr_t a;
        e0 = errors;
        a  = make_addr(23'h01234, 6'd3, 3'd0);
        access(1'b1, a, 64'h1122_3344_5566_7788, 8'b1010_0101);
        access(1'b0, a, '0, '0);
        finish_test("write_merge", e0);
    endtask

    task automatic test_dirty_evict();
        int    e0;
        addr_t a;
        addr_t b;
        addr_t c;
        e0 = errors;
        a  = make_addr(23'h000aa, 6'd10, 3'd0);
        b  = make_addr(23'h000bb, 6'd10, 3'd0);
        c  = make_addr(23'h000cc, 6'd10, 3'd0);
        access(1'b1, a, 64'hdead_beef_0bad_f00d, 8'h0f);
        access(1'b1, b, 64'h0123_4567_89ab_cdef, 8'hf0);
        access(1'b0, c, '0, '0);
        check_value("evicted line", 64'(a), 64'(last_wb_addr));
        access(1'b0, a, '0, '0);
        finish_test("dirty_evict", e0);
    endtask

    task automatic test_age_order();
        int e0;
        e0 = errors;
        access(1'b1, make_addr(23'h00a00, 6'd20, 3'd0), 64'h1, 8'hff);
        access(1'b1, make_addr(23'h00b00, 6'd20, 3'd0), 64'h2, 8'hff);
        access(1'b1, make_addr(23'h00c00, 6'd20, 3'd0), 64'h3, 8'hff);
        check_value("evicted line", 64'(make_addr(23'h00a00, 6'd20, 3'd0)), 64'(last_wb_addr));
        access(1'b1, make_addr(23'h00a00, 6'd21, 3'd0), 64'h4, 8'hff);
        access(1'b1, make_addr(23'h00b00, 6'd21, 3'd0), 64'h5, 8'hff);
        access(1'b0, make_addr(23'h00a00, 6'd21, 3'd0), '0, '0);
        access(1'b1, make_addr(23'h00c00, 6'd21, 3'd0), 64'h6, 8'hff);
        check_value("evicted line", 64'(make_addr(23'h00b00, 6'd21, 3'd0)), 64'(last_wb_addr));
        finish_test("age_order", e0);
    endtask

    // few tags over few sets, so misses and evictions are frequent
    task automatic test_random_traffic();
        int          e0;
        logic [31:0] r;
        word_t       wdata;
        e0 = errors;
        for (int n = 0; n < RANDOM_ACCESSES; n++) begin
            r     = $random(seed);
            wdata = {$random(seed), $random(seed)};
            access(r[7], make_addr({21'h000100, r[1:0]}, {4'b1010, r[3:2]}, r[6:4]),
                   wdata, r[15:8]);
        end
        finish_test("random_traffic", e0);
    endtask

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_strb_i  = '0;
        for (int s = 0; s < `DC_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        test_reset();
        test_read_miss_hit();
        test_write_merge();
        test_dirty_evict();
        test_age_order();
        test_random_traffic();
        $display("tests run %0d, failing tests %0d, wrong checks %0d",
                 tests_run, tests_failing, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule
